// File: alarm_clock.f
+incdir+.
clock_time_pkg.sv
clock_audio_pkg.sv
panel_input.sv
time_keeper.sv
melody_recorder.sv
tone_generator.sv
alarm_clock.sv
tb_clock_gen.sv
alarm_clock_tb.sv

// File: alarm_clock.sv
`timescale 1ns/10ps
`default_nettype none

module alarm_clock (
    input  wire                                clock,
    input  wire                                reset,
    input  wire clock_time_pkg::mode_switch_t  mode,
    input  wire clock_time_pkg::button_t       button,
    output clock_time_pkg::hour_t              hour,
    output clock_time_pkg::minute_t            minute,
    output clock_time_pkg::second_t            second,
    output clock_time_pkg::hour_t              alarm_hour,
    output clock_time_pkg::minute_t            alarm_minute,
    output logic                               alarm_enabled,
    output clock_audio_pkg::led_t              led,
    output logic                               piezo
);
    logic                        tick;
    clock_time_pkg::button_t     press;
    clock_time_pkg::panel_mode_t panel_mode;
    logic                        alarm_start;
    clock_audio_pkg::note_t      note;

    panel_input panel_input_inst (
        .clock      (clock),
        .reset      (reset),
        .mode       (mode),
        .button     (button),
        .tick       (tick),
        .press      (press),
        .panel_mode (panel_mode)
    );

    time_keeper time_keeper_inst (
        .clock         (clock),
        .reset         (reset),
        .tick          (tick),
        .press         (press),
        .panel_mode    (panel_mode),
        .hour          (hour),
        .alarm_hour    (alarm_hour),
        .minute        (minute),
        .alarm_minute  (alarm_minute),
        .second        (second),
        .alarm_enabled (alarm_enabled),
        .alarm_start   (alarm_start)
    );

    melody_recorder melody_recorder_inst (
        .clock         (clock),
        .reset         (reset),
        .tick          (tick),
        .alarm_start   (alarm_start),
        .alarm_enabled (alarm_enabled),
        .press         (press),
        .panel_mode    (panel_mode),
        .note          (note),
        .led           (led)
    );

    tone_generator tone_generator_inst (
        .clock (clock),
        .reset (reset),
        .note  (note),
        .piezo (piezo)
    );

endmodule

`default_nettype wire

// File: alarm_clock_cfg.svh
`ifndef ALARM_CLOCK_CFG_SVH
`define ALARM_CLOCK_CFG_SVH

`define CLK_TICK_DIV      1000
`define TICKS_PER_SECOND  1000
`define STEP_TICKS        125
`define MELODY_SLOTS      64
`define SLOTS_PER_NOTE    4

`define BTN_COUNT         12
`define BTN_HOUR_DN       11
`define BTN_HOUR_UP       9
`define BTN_MIN_DN        8
`define BTN_MIN_UP        6
`define BTN_SEC_DN        5
`define BTN_SEC_UP        3
`define BTN_TOGGLE        1
`define BTN_PLAY          1
`define BTN_CLEAR         0

// Full tone periods in system clocks
`define TONE_C2           12'd3830
`define TONE_D2           12'd3400
`define TONE_E2           12'd3038
`define TONE_F2           12'd2864
`define TONE_G2           12'd2550
`define TONE_A2           12'd2272
`define TONE_B2           12'd2028
`define TONE_C3           12'd1912
`define TONE_D3           12'd1704

`define MODE_SET_TIME     7'b1000000
`define MODE_SET_ALARM    7'b0010000
`define MODE_RECORD       7'b0000100

`endif

// File: alarm_clock_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "alarm_clock_cfg.svh"

module alarm_clock_tb;
    localparam int tick_clocks = `CLK_TICK_DIV;
    localparam int second_clocks = (`TICKS_PER_SECOND + 50) * `CLK_TICK_DIV;
    localparam int slot_clocks = `STEP_TICKS * `CLK_TICK_DIV;

    wire                           clock;
    wire                           reset;
    clock_time_pkg::mode_switch_t  mode;
    clock_time_pkg::button_t       button;
    clock_time_pkg::hour_t         hour;
    clock_time_pkg::minute_t       minute;
    clock_time_pkg::second_t       second;
    clock_time_pkg::hour_t         alarm_hour;
    clock_time_pkg::minute_t       alarm_minute;
    logic                          alarm_enabled;
    clock_audio_pkg::led_t         led;
    logic                          piezo;
    int                            error_count = 0;

    tb_clock_gen clock_gen_inst (.clock(clock), .reset(reset));

    alarm_clock alarm_clock_inst (
        .clock         (clock),
        .reset         (reset),
        .mode          (mode),
        .button        (button),
        .hour          (hour),
        .minute        (minute),
        .second        (second),
        .alarm_hour    (alarm_hour),
        .alarm_minute  (alarm_minute),
        .alarm_enabled (alarm_enabled),
        .led           (led),
        .piezo         (piezo)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR time=%0t %s expected=%0d actual=%0d", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic wait_ticks(input int count);
        repeat (count * tick_clocks) @(negedge clock);
    endtask

    // Held for two tick samples, released for two more
    task automatic press_button(input int index);
        @(negedge clock) button = clock_time_pkg::button_t'(1) << index;
        wait_ticks(2);
        button = '0;
        wait_ticks(2);
    endtask

    task automatic set_mode(input clock_time_pkg::mode_switch_t pattern);
        @(negedge clock) mode = pattern;
    endtask

    // Clocks from one piezo edge to the next
    task automatic measure_half_period(input int limit, output int half, output int used);
        logic level;
        int   count;
        half = 0;
        used = 0;
        count = 0;
        @(negedge clock);
        level = piezo;
        while (piezo == level && used < limit) begin
            @(negedge clock);
            used++;
        end
        if (piezo == level) begin
            $display("Timed out waiting for the piezo to start toggling");
            error_count++;
            return;
        end
        level = piezo;
        while (piezo == level && used < limit) begin
            @(negedge clock);
            used++;
            count++;
        end
        if (piezo == level) begin
            $display("Timed out waiting for the next piezo edge");
            error_count++;
        end else begin
            half = count;
        end
    endtask

    task automatic check_reset_state;
        int waited;
        waited = 0;
        while (!reset && waited < 100) begin
            @(negedge clock);
            waited++;
        end
        if (!reset) begin
            $display("Reset was never released");
            error_count++;
        end
        @(negedge clock);
        check_value("hour", 0, hour);
        check_value("minute", 0, minute);
        check_value("second", 0, second);
        check_value("alarm_hour", 0, alarm_hour);
        check_value("alarm_minute", 0, alarm_minute);
        check_value("alarm_enabled", 0, alarm_enabled);
        check_value("led", 0, led);
        check_value("piezo", 0, piezo);
    endtask

    task automatic set_time_with_wrap;
        set_mode(`MODE_SET_TIME);
        press_button(`BTN_HOUR_DN);
        check_value("hour", 23, hour);
        press_button(`BTN_HOUR_UP);
        check_value("hour", 0, hour);
        press_button(`BTN_MIN_DN);
        check_value("minute", 59, minute);
        repeat (3) press_button(`BTN_SEC_UP);
        check_value("second", 3, second);
    endtask

    task automatic run_rollover;
        int waited;
        press_button(`BTN_HOUR_DN);
        repeat (4) press_button(`BTN_SEC_DN);  // 3 down to 59
        check_value("hour", 23, hour);
        check_value("minute", 59, minute);
        check_value("second", 59, second);
        set_mode(7'b0);
        waited = 0;
        while (!(hour == 0 && minute == 0 && second == 0) && waited < second_clocks) begin
            @(negedge clock);
            waited++;
        end
        if (!(hour == 0 && minute == 0 && second == 0)) begin
            $display("Time did not roll over to midnight in time");
            error_count++;
        end
        mode = `MODE_SET_TIME;  // Freeze right after the rollover
        wait_ticks(`TICKS_PER_SECOND + 50);
        check_value("second", 0, second);
    endtask

    task automatic ring_alarm;
        int half;
        int used;
        set_mode(`MODE_SET_ALARM);
        press_button(`BTN_MIN_UP);
        press_button(`BTN_TOGGLE);
        check_value("alarm_hour", 0, alarm_hour);
        check_value("alarm_minute", 1, alarm_minute);
        check_value("alarm_enabled", 1, alarm_enabled);
        check_value("led[0]", 1, led[0]);
        set_mode(`MODE_SET_TIME);
        press_button(`BTN_SEC_DN);
        check_value("second", 59, second);
        set_mode(7'b0);
        measure_half_period(second_clocks, half, used);
        check_value("piezo half period", `TONE_C3 / 2 + 1, half);  // Default tune, C3
    endtask

    task automatic record_and_play;
        int half;
        int used;
        int total;
        int quiet;
        set_mode(`MODE_RECORD);
        press_button(`BTN_CLEAR);
        check_value("led", 8'hff, led);
        press_button(11);  // Note 1, C2
        press_button(3);   // Note 9, D3
        check_value("led", 8'h80, led);
        press_button(`BTN_PLAY);
        measure_half_period(10000, half, used);
        check_value("piezo half period", `TONE_C2 / 2 + 1, half);
        total = 0;
        half = 0;
        while (half != `TONE_D3 / 2 + 1 && total < 700 * tick_clocks) begin
            measure_half_period(10000, half, used);
            total += used;
        end
        check_value("piezo half period", `TONE_D3 / 2 + 1, half);
        // Playback ends after 8 slots, so silence outlasts a whole slot
        total = 0;
        quiet = 0;
        while (quiet < slot_clocks + 10 * tick_clocks && total < 700 * tick_clocks) begin
            @(negedge clock);
            total++;
            quiet = piezo ? 0 : quiet + 1;
        end
        if (quiet < slot_clocks + 10 * tick_clocks) begin
            $display("Piezo kept sounding after the recorded melody ended");
            error_count++;
        end
        check_value("piezo", 0, piezo);
    endtask

    initial begin
        mode = '0;
        button = '0;
        check_reset_state();
        set_time_with_wrap();
        run_rollover();
        ring_alarm();
        record_and_play();
        $display("Run complete with %0d errors", error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: clock_audio_pkg.sv
`default_nettype none

`include "alarm_clock_cfg.svh"

package clock_audio_pkg;

    // 0 is a rest, 1 to 9 run from C2 up to D3
    typedef logic [3:0] note_t;

    typedef logic [$clog2(`MELODY_SLOTS)-1:0] slot_index_t;

    typedef logic [7:0] led_t;

    // Wide enough for the longest tone period
    typedef logic [11:0] tone_count_t;

endpackage

`default_nettype wire

// File: clock_time_pkg.sv
`default_nettype none

`include "alarm_clock_cfg.svh"

package clock_time_pkg;

    typedef logic [4:0] hour_t;    // 0 to 23
    typedef logic [5:0] minute_t;
    typedef logic [5:0] second_t;

    // One bit per panel button, bit 11 is leftmost
    typedef logic [`BTN_COUNT-1:0] button_t;

    typedef logic [6:0] mode_switch_t;  // Raw slide switches

    typedef enum logic [1:0] {
        MODE_RUN,
        MODE_SET_TIME,
        MODE_SET_ALARM,
        MODE_RECORD
    } panel_mode_t;

endpackage

`default_nettype wire

// File: melody_recorder.sv
`timescale 1ns/10ps
`default_nettype none

`include "alarm_clock_cfg.svh"

module melody_recorder (
    input  wire                               clock,
    input  wire                               reset,
    input  wire                               tick,
    input  wire                               alarm_start,
    input  wire                               alarm_enabled,
    input  wire clock_time_pkg::button_t      press,
    input  wire clock_time_pkg::panel_mode_t  panel_mode,
    output clock_audio_pkg::note_t            note,
    output clock_audio_pkg::led_t             led
);
    localparam int step_width = $clog2(`STEP_TICKS);
    localparam int note_key_low = 3;
    localparam int note_key_high = 11;

    localparam clock_time_pkg::button_t clear_key = clock_time_pkg::button_t'(1) << `BTN_CLEAR;
    localparam clock_time_pkg::button_t play_key  = clock_time_pkg::button_t'(1) << `BTN_PLAY;

    clock_audio_pkg::note_t      melody [`MELODY_SLOTS];
    clock_audio_pkg::slot_index_t melody_index;
    clock_audio_pkg::slot_index_t play_index;
    clock_audio_pkg::slot_index_t play_last;
    logic [step_width-1:0]       step_count;
    logic                        playing;
    logic                        record_mode;
    logic                        key_valid;
    clock_audio_pkg::note_t      key_note;

    // Default tune is C3 on every other slot of the first half
    initial begin
        for (int i = 0; i < `MELODY_SLOTS; i++) begin
            melody[i] = (i < `MELODY_SLOTS / 2 && i % 2 == 0) ? 4'd8 : 4'd0;
        end
    end

    assign record_mode = (panel_mode == clock_time_pkg::MODE_RECORD);
    assign play_last = (melody_index == '0) ? clock_audio_pkg::slot_index_t'(`MELODY_SLOTS - 1)
                                            : melody_index - 1'b1;

    // Button 11 is C2 down to button 3 for D3
    always_comb begin
        key_valid = 1'b0;
        key_note = '0;
        for (int i = note_key_low; i <= note_key_high; i++) begin
            if (press == (clock_time_pkg::button_t'(1) << i)) begin
                key_valid = 1'b1;
                key_note = clock_audio_pkg::note_t'(note_key_high + 1 - i);
            end
        end
    end

    always @(posedge clock) begin
        if (record_mode && key_valid) begin
            for (int k = 0; k < `SLOTS_PER_NOTE; k++) begin
                melody[clock_audio_pkg::slot_index_t'(melody_index + k)] <= key_note;
            end
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            melody_index <= '0;
            play_index <= '0;
            step_count <= '0;
            playing <= 1'b0;
        end else begin
            if (playing && tick) begin
                if (step_count == step_width'(`STEP_TICKS - 1)) begin
                    step_count <= '0;
                    if (play_index == play_last) begin
                        play_index <= '0;
                        playing <= 1'b0;
                    end else begin
                        play_index <= play_index + 1'b1;
                    end
                end else begin
                    step_count <= step_count + 1'b1;
                end
            end

            if (record_mode) begin
                if (press == clear_key) begin
                    melody_index <= '0;
                    play_index <= '0;
                    step_count <= '0;
                    playing <= 1'b0;
                end else if (press == play_key) begin
                    play_index <= '0;
                    step_count <= '0;
                    playing <= 1'b1;
                end else if (key_valid) begin
                    melody_index <= melody_index + clock_audio_pkg::slot_index_t'(`SLOTS_PER_NOTE);
                end
            end

            if (alarm_start) begin  // Alarm wins over panel
                play_index <= '0;
                step_count <= '0;
                playing <= 1'b1;
            end
        end
    end

    assign note = playing ? melody[play_index] : '0;

    // One lit LED from the top per 8 recorded slots
    always_comb begin
        if (!record_mode) begin
            led = clock_audio_pkg::led_t'(alarm_enabled);
        end else if (melody_index == '0) begin
            led = '1;
        end else begin
            led = clock_audio_pkg::led_t'(16'hff00 >> (melody_index >> 3));
        end
    end

    a_play_in_range: assert property (
        @(posedge clock) disable iff (!reset)
        playing |-> (play_index <= play_last)
    );

endmodule

`default_nettype wire

// File: panel_input.sv
`timescale 1ns/10ps
`default_nettype none

`include "alarm_clock_cfg.svh"

module panel_input (
    input  wire                                clock,
    input  wire                                reset,
    input  wire clock_time_pkg::mode_switch_t  mode,
    input  wire clock_time_pkg::button_t       button,
    output logic                               tick,
    output clock_time_pkg::button_t            press,
    output clock_time_pkg::panel_mode_t        panel_mode
);
    localparam int div_width = $clog2(`CLK_TICK_DIV);

    logic [div_width-1:0]    div_count;
    clock_time_pkg::button_t button_sample;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            div_count <= '0;
            tick <= 1'b0;
        end else if (div_count == div_width'(`CLK_TICK_DIV - 1)) begin
            div_count <= '0;
            tick <= 1'b1;
        end else begin
            div_count <= div_count + 1'b1;
            tick <= 1'b0;
        end
    end

    // Buttons sampled at tick rate
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            button_sample <= '0;
            press <= '0;
        end else if (tick) begin
            button_sample <= button;
            press <= button & ~button_sample;  // Rising edges only
        end else begin
            press <= '0;
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            panel_mode <= clock_time_pkg::MODE_RUN;
        end else begin
            case (mode)
                `MODE_SET_TIME:  panel_mode <= clock_time_pkg::MODE_SET_TIME;
                `MODE_SET_ALARM: panel_mode <= clock_time_pkg::MODE_SET_ALARM;
                `MODE_RECORD:    panel_mode <= clock_time_pkg::MODE_RECORD;
                default:         panel_mode <= clock_time_pkg::MODE_RUN;  // Incl. unused switches
            endcase
        end
    end

    // Press follows a tick and stays one clock wide
    a_press_after_tick: assert property (
        @(posedge clock) disable iff (!reset)
        (press != '0) |-> ($past(tick) && !tick)
    );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clock,
    output logic reset
);
    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;  // 4 ns period
    end

    initial begin
        reset = 1'b0;
        repeat (2) @(posedge clock);
        @(negedge clock) reset = 1'b1;  // Release away from the active edge
    end

endmodule

`default_nettype wire

// File: time_keeper.sv
`timescale 1ns/10ps
`default_nettype none

`include "alarm_clock_cfg.svh"

module time_keeper (
    input  wire                               clock,
    input  wire                               reset,
    input  wire                               tick,
    input  wire clock_time_pkg::button_t      press,
    input  wire clock_time_pkg::panel_mode_t  panel_mode,
    output clock_time_pkg::hour_t             hour,
    output clock_time_pkg::hour_t             alarm_hour,
    output clock_time_pkg::minute_t           minute,
    output clock_time_pkg::minute_t           alarm_minute,
    output clock_time_pkg::second_t           second,
    output logic                              alarm_enabled,
    output logic                              alarm_start
);
    localparam int sub_width = $clog2(`TICKS_PER_SECOND);

    // Single-button press patterns
    localparam clock_time_pkg::button_t hour_dn_key = clock_time_pkg::button_t'(1) << `BTN_HOUR_DN;
    localparam clock_time_pkg::button_t hour_up_key = clock_time_pkg::button_t'(1) << `BTN_HOUR_UP;
    localparam clock_time_pkg::button_t min_dn_key  = clock_time_pkg::button_t'(1) << `BTN_MIN_DN;
    localparam clock_time_pkg::button_t min_up_key  = clock_time_pkg::button_t'(1) << `BTN_MIN_UP;
    localparam clock_time_pkg::button_t sec_dn_key  = clock_time_pkg::button_t'(1) << `BTN_SEC_DN;
    localparam clock_time_pkg::button_t sec_up_key  = clock_time_pkg::button_t'(1) << `BTN_SEC_UP;
    localparam clock_time_pkg::button_t toggle_key  = clock_time_pkg::button_t'(1) << `BTN_TOGGLE;

    logic [sub_width-1:0] sub_count;
    logic                 alarm_match;
    logic                 match_q;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            sub_count <= '0;
            hour <= '0;
            minute <= '0;
            second <= '0;
            alarm_hour <= '0;
            alarm_minute <= '0;
            alarm_enabled <= 1'b0;
        end else begin
            case (panel_mode)
                clock_time_pkg::MODE_SET_TIME: begin
                    case (press)
                        hour_dn_key: hour <= (hour == 0) ? 5'd23 : hour - 1'b1;
                        hour_up_key: hour <= (hour == 23) ? 5'd0 : hour + 1'b1;
                        min_dn_key:  minute <= (minute == 0) ? 6'd59 : minute - 1'b1;
                        min_up_key:  minute <= (minute == 59) ? 6'd0 : minute + 1'b1;
                        sec_dn_key:  second <= (second == 0) ? 6'd59 : second - 1'b1;
                        sec_up_key:  second <= (second == 59) ? 6'd0 : second + 1'b1;
                        default: ;  // Multi-button presses land here
                    endcase
                end
                clock_time_pkg::MODE_SET_ALARM: begin
                    case (press)
                        hour_dn_key: alarm_hour <= (alarm_hour == 0) ? 5'd23 : alarm_hour - 1'b1;
                        hour_up_key: alarm_hour <= (alarm_hour == 23) ? 5'd0 : alarm_hour + 1'b1;
                        min_dn_key:
                            alarm_minute <= (alarm_minute == 0) ? 6'd59 : alarm_minute - 1'b1;
                        min_up_key:
                            alarm_minute <= (alarm_minute == 59) ? 6'd0 : alarm_minute + 1'b1;
                        toggle_key:  alarm_enabled <= ~alarm_enabled;
                        default: ;
                    endcase
                end
                clock_time_pkg::MODE_RUN: begin
                    if (tick) begin
                        if (sub_count == sub_width'(`TICKS_PER_SECOND - 1)) begin
                            sub_count <= '0;
                            second <= second + 1'b1;
                            if (second == 59) begin
                                second <= '0;
                                minute <= minute + 1'b1;
                                if (minute == 59) begin
                                    minute <= '0;
                                    hour <= (hour == 23) ? 5'd0 : hour + 1'b1;
                                end
                            end
                        end else begin
                            sub_count <= sub_count + 1'b1;
                        end
                    end
                end
                default: ;  // Record mode, time holds
            endcase
        end
    end

    assign alarm_match = alarm_enabled && (hour == alarm_hour) && (minute == alarm_minute)
                         && (second == 0);

    // Start pulse on the first clock of a match
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            match_q <= 1'b0;
            alarm_start <= 1'b0;
        end else begin
            match_q <= alarm_match;
            alarm_start <= alarm_match && !match_q;
        end
    end

    a_time_range: assert property (
        @(posedge clock) disable iff (!reset)
        (hour < 24) && (minute < 60) && (second < 60)
    );

endmodule

`default_nettype wire

// File: tone_generator.sv
`timescale 1ns/10ps
`default_nettype none

`include "alarm_clock_cfg.svh"

module tone_generator (
    input  wire                          clock,
    input  wire                          reset,
    input  wire clock_audio_pkg::note_t  note,
    output logic                         piezo
);
    clock_audio_pkg::tone_count_t period;
    clock_audio_pkg::tone_count_t tone_count;

    always_comb begin
        case (note)
            4'd1:    period = `TONE_C2;
            4'd2:    period = `TONE_D2;
            4'd3:    period = `TONE_E2;
            4'd4:    period = `TONE_F2;
            4'd5:    period = `TONE_G2;
            4'd6:    period = `TONE_A2;
            4'd7:    period = `TONE_B2;
            4'd8:    period = `TONE_C3;
            4'd9:    period = `TONE_D3;
            default: period = '0;  // Rest
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            tone_count <= '0;
            piezo <= 1'b0;
        end else if (period == '0) begin
            tone_count <= '0;
            piezo <= 1'b0;
        end else if (tone_count >= (period >> 1)) begin
            tone_count <= '0;
            piezo <= ~piezo;  // Half period done
        end else begin
            tone_count <= tone_count + 1'b1;
        end
    end

endmodule

`default_nettype wire
